//--- source/fmul_pkg.sv
// Single-precision multiplier definitions
package fmul_pkg;

  // binary32 format
  localparam int EXP_W    = 8;
  localparam int SIG_W    = 24;
  localparam int FP_W     = 32;
  localparam int EXP_BIAS = 127;
  localparam int PROD_W   = 2 * SIG_W;

  localparam int OP_W     = 3;
  localparam int RM_W     = 3;
  localparam int FFLAGS_W = 5;

  // fused ops that negate the product
  localparam logic [OP_W-1:0] OP_FNMADD = 3'd6;
  localparam logic [OP_W-1:0] OP_FNMSUB = 3'd7;

  localparam logic [RM_W-1:0] RM_RNE = 3'd0;
  localparam logic [RM_W-1:0] RM_RTZ = 3'd1;
  localparam logic [RM_W-1:0] RM_RDN = 3'd2;
  localparam logic [RM_W-1:0] RM_RUP = 3'd3;
  localparam logic [RM_W-1:0] RM_RMM = 3'd4;

  // flag bit positions
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam logic [FP_W-1:0] CANON_NAN = 32'h7fc00000;

  typedef logic [FP_W-1:0]            fp_word_t;
  typedef logic [SIG_W-1:0]           sig_t;
  typedef logic [PROD_W-1:0]          prod_t;
  // two extra bits so sums below zero or above 255 stay exact
  typedef logic signed [EXP_W+1:0]    exp_calc_t;
  typedef logic [OP_W-1:0]            op_t;
  typedef logic [RM_W-1:0]            rm_t;
  typedef logic [FFLAGS_W-1:0]        fflags_t;

endpackage

//--- source/fmul_pipe_ctrl.sv
// Multiplier pipeline control
`timescale 1ns/100ps

module fmul_pipe_ctrl import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  input  logic     out_ready_i,
  input  op_t      in_op_i,
  input  fp_word_t in_c_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output logic     en_s1_o,
  output logic     en_s2_o,
  output op_t      op_o,
  output fp_word_t c_o
);

  logic     valid_s2;
  logic     valid_s3;
  logic     s3_blocked;
  logic     stall;
  op_t      op_s2;
  fp_word_t c_s2;

  // stage 3 cannot drain this cycle
  assign s3_blocked = valid_s3 && !out_ready_i;
  // both stages full and nothing leaving
  assign stall      = valid_s2 && s3_blocked;

  assign in_ready_o  = !stall;
  assign out_valid_o = valid_s3;
  assign en_s1_o     = in_valid_i && !stall;
  assign en_s2_o     = valid_s2 && !s3_blocked;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s2 <= 1'b0;
      valid_s3 <= 1'b0;
    end else begin
      if (!stall) begin
        valid_s2 <= in_valid_i;
      end
      if (!s3_blocked) begin
        valid_s3 <= valid_s2;
      end
    end
  end

  // op and operand c ride along with the product
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_s2 <= '0;
      c_s2  <= '0;
      op_o  <= '0;
      c_o   <= '0;
    end else begin
      if (en_s1_o) begin
        op_s2 <= in_op_i;
        c_s2  <= in_c_i;
      end
      if (en_s2_o) begin
        op_o <= op_s2;
        c_o  <= c_s2;
      end
    end
  end

endmodule

//--- source/fmul_exp_path.sv
// Multiplier sign, exponent and special cases
`timescale 1ns/100ps

module fmul_exp_path import fmul_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en_i,
  input  fp_word_t  a_i,
  input  fp_word_t  b_i,
  input  op_t       op_i,
  input  rm_t       rm_i,
  output logic      sign_o,
  output exp_calc_t exp_o,
  output logic      special_o,
  output logic      special_nan_o,
  output logic      special_inf_o,
  output logic      special_inv_o,
  output logic      special_zero_o,
  output rm_t       rm_o
);

  logic [EXP_W-1:0] a_exp;
  logic [EXP_W-1:0] b_exp;
  logic             a_frac_zero;
  logic             b_frac_zero;
  logic             a_zero, b_zero;
  logic             a_inf, b_inf;
  logic             a_nan, b_nan;
  logic             a_snan, b_snan;
  logic             neg;
  exp_calc_t        a_eff, b_eff;
  exp_calc_t        exp_sum;
  logic             any_nan, any_inf, any_inv, any_zero;

  assign a_exp       = a_i[FP_W-2 -: EXP_W];
  assign b_exp       = b_i[FP_W-2 -: EXP_W];
  assign a_frac_zero = (a_i[SIG_W-2:0] == '0);
  assign b_frac_zero = (b_i[SIG_W-2:0] == '0);

  // operand classes
  assign a_zero = (a_exp == '0) && a_frac_zero;
  assign b_zero = (b_exp == '0) && b_frac_zero;
  assign a_inf  = (a_exp == '1) && a_frac_zero;
  assign b_inf  = (b_exp == '1) && b_frac_zero;
  assign a_nan  = (a_exp == '1) && !a_frac_zero;
  assign b_nan  = (b_exp == '1) && !b_frac_zero;
  // quiet bit clear marks a signaling NaN
  assign a_snan = a_nan && !a_i[SIG_W-2];
  assign b_snan = b_nan && !b_i[SIG_W-2];

  assign neg = (op_i == OP_FNMADD) || (op_i == OP_FNMSUB);

  // subnormals share the exponent of the smallest normal
  assign a_eff   = (a_exp == '0) ? exp_calc_t'(1) : $signed({2'b00, a_exp});
  assign b_eff   = (b_exp == '0) ? exp_calc_t'(1) : $signed({2'b00, b_exp});
  assign exp_sum = a_eff + b_eff - exp_calc_t'(EXP_BIAS);

  assign any_nan  = a_nan || b_nan;
  assign any_inf  = a_inf || b_inf;
  assign any_zero = a_zero || b_zero;
  assign any_inv  = (a_inf && b_zero) || (b_inf && a_zero) || a_snan || b_snan;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sign_o         <= 1'b0;
      exp_o          <= '0;
      special_o      <= 1'b0;
      special_nan_o  <= 1'b0;
      special_inf_o  <= 1'b0;
      special_inv_o  <= 1'b0;
      special_zero_o <= 1'b0;
      rm_o           <= '0;
    end else if (en_i) begin
      sign_o         <= a_i[FP_W-1] ^ b_i[FP_W-1] ^ neg;
      exp_o          <= exp_sum;
      special_o      <= any_nan || any_inf || any_zero;
      special_nan_o  <= any_nan;
      special_inf_o  <= any_inf;
      special_inv_o  <= any_inv;
      special_zero_o <= any_zero;
      rm_o           <= rm_i;
    end
  end

endmodule

//--- source/fmul_sig_mult.sv
// Significand multiplier
`timescale 1ns/100ps

module fmul_sig_mult import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en_i,
  input  fp_word_t a_i,
  input  fp_word_t b_i,
  output prod_t    prod_o
);

  sig_t  a_sig;
  sig_t  b_sig;
  prod_t prod;

  // hidden bit is one unless the exponent field is zero
  assign a_sig = {(a_i[FP_W-2 -: EXP_W] != '0), a_i[SIG_W-2:0]};
  assign b_sig = {(b_i[FP_W-2 -: EXP_W] != '0), b_i[SIG_W-2:0]};

  // 2.46 fixed point product
  assign prod = a_sig * b_sig;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_o <= '0;
    end else if (en_i) begin
      prod_o <= prod;
    end
  end

endmodule

//--- source/fmul_normalize.sv
// Product normalization
`timescale 1ns/100ps

module fmul_normalize import fmul_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en_i,
  input  prod_t            prod_i,
  input  exp_calc_t        exp_i,
  input  logic             sign_i,
  input  logic             special_i,
  input  logic             special_nan_i,
  input  logic             special_inf_i,
  input  logic             special_inv_i,
  input  logic             special_zero_i,
  input  rm_t              rm_i,
  output logic [SIG_W+1:0] sig_o,
  output logic             sticky_o,
  output exp_calc_t        exp_o,
  output logic             sign_o,
  output logic             special_o,
  output logic             special_nan_o,
  output logic             special_inf_o,
  output logic             special_inv_o,
  output logic             special_zero_o,
  output rm_t              rm_o
);

  function automatic logic [5:0] count_lz(input prod_t p);
    logic [5:0] n;
    logic       found;
    n     = 6'd0;
    found = 1'b0;
    for (int i = PROD_W - 1; i >= 0; i--) begin
      if (!found) begin
        if (p[i]) begin
          found = 1'b1;
        end else begin
          n = n + 6'd1;
        end
      end
    end
    return n;
  endfunction

  logic [5:0]          lz;
  prod_t               shifted;
  exp_calc_t           norm_exp;
  exp_calc_t           rsh_full;
  logic [5:0]          rsh;
  exp_calc_t           exp_n;
  logic [2*PROD_W-1:0] wide;
  logic [SIG_W+1:0]    sig_n;
  logic                sticky_n;

  always_comb begin
    lz      = count_lz(prod_i);
    shifted = prod_i << lz;
    // leading one at bit 47 means one above the summed exponent
    norm_exp = exp_i + exp_calc_t'(1) - $signed({4'b0000, lz});
    rsh_full = exp_calc_t'(1) - norm_exp;
    if (norm_exp < exp_calc_t'(1)) begin
      // subnormal result shifts down to exponent 1
      exp_n = exp_calc_t'(1);
      rsh   = (rsh_full > exp_calc_t'(PROD_W)) ? 6'(PROD_W) : rsh_full[5:0];
    end else begin
      exp_n = norm_exp;
      rsh   = 6'd0;
    end
    wide     = {shifted, {PROD_W{1'b0}}} >> rsh;
    sig_n    = wide[2*PROD_W-1 -: SIG_W+2];
    sticky_n = |wide[2*PROD_W-SIG_W-3:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sig_o          <= '0;
      sticky_o       <= 1'b0;
      exp_o          <= '0;
      sign_o         <= 1'b0;
      special_o      <= 1'b0;
      special_nan_o  <= 1'b0;
      special_inf_o  <= 1'b0;
      special_inv_o  <= 1'b0;
      special_zero_o <= 1'b0;
      rm_o           <= '0;
    end else if (en_i) begin
      sig_o          <= sig_n;
      sticky_o       <= sticky_n;
      exp_o          <= exp_n;
      sign_o         <= sign_i;
      special_o      <= special_i;
      special_nan_o  <= special_nan_i;
      special_inf_o  <= special_inf_i;
      special_inv_o  <= special_inv_i;
      special_zero_o <= special_zero_i;
      rm_o           <= rm_i;
    end
  end

endmodule

//--- source/fmul_round.sv
// Rounding and result selection
`timescale 1ns/100ps

module fmul_round import fmul_pkg::*; (
  input  logic [SIG_W+1:0] sig_i,
  input  logic             sticky_i,
  input  exp_calc_t        exp_i,
  input  logic             sign_i,
  input  logic             special_i,
  input  logic             special_nan_i,
  input  logic             special_inf_i,
  input  logic             special_inv_i,
  input  logic             special_zero_i,
  input  rm_t              rm_i,
  output fp_word_t         result_o,
  output fflags_t          fflags_o
);

  logic             g_bit;
  logic             r_bit;
  logic             lsb;
  logic             inexact;
  logic             round_up;
  logic [SIG_W:0]   rounded;
  logic             carry;
  logic             hidden;
  logic [SIG_W-2:0] frac;
  exp_calc_t        exp_r;
  logic             ovf;
  logic             ovf_to_inf;
  logic             tiny;

  always_comb begin
    g_bit   = sig_i[1];
    r_bit   = sig_i[0];
    lsb     = sig_i[2];
    inexact = g_bit || r_bit || sticky_i;

    case (rm_i)
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = inexact && sign_i;
      RM_RUP:  round_up = inexact && !sign_i;
      RM_RMM:  round_up = g_bit;
      // RNE and undefined codes
      default: round_up = g_bit && (r_bit || sticky_i || lsb);
    endcase

    rounded = {1'b0, sig_i[SIG_W+1:2]} + {{SIG_W{1'b0}}, round_up};
    carry   = rounded[SIG_W];
    if (carry) begin
      frac   = rounded[SIG_W-1:1];
      hidden = 1'b1;
    end else begin
      frac   = rounded[SIG_W-2:0];
      hidden = rounded[SIG_W-1];
    end
    exp_r = exp_i + $signed({{(EXP_W+1){1'b0}}, carry});

    ovf        = exp_r >= exp_calc_t'((1 << EXP_W) - 1);
    ovf_to_inf = (rm_i == RM_RNE) || (rm_i == RM_RMM) ||
                 ((rm_i == RM_RUP) && !sign_i) || ((rm_i == RM_RDN) && sign_i);
    // tininess judged on the rounded result
    tiny       = !hidden;

    fflags_o = '0;
    if (ovf) begin
      if (ovf_to_inf) begin
        result_o = {sign_i, {EXP_W{1'b1}}, {(SIG_W-1){1'b0}}};
      end else begin
        // largest finite magnitude
        result_o = {sign_i, {(EXP_W-1){1'b1}}, 1'b0, {(SIG_W-1){1'b1}}};
      end
      fflags_o[FLAG_OF] = 1'b1;
      fflags_o[FLAG_NX] = 1'b1;
    end else begin
      result_o          = {sign_i, (hidden ? exp_r[EXP_W-1:0] : {EXP_W{1'b0}}), frac};
      fflags_o[FLAG_UF] = tiny && inexact;
      fflags_o[FLAG_NX] = inexact;
    end

    // special operands override the datapath
    if (special_i) begin
      fflags_o = '0;
      if (special_inv_i) begin
        result_o          = CANON_NAN;
        fflags_o[FLAG_NV] = 1'b1;
      end else if (special_nan_i) begin
        result_o = CANON_NAN;
      end else if (special_inf_i) begin
        result_o = {sign_i, {EXP_W{1'b1}}, {(SIG_W-1){1'b0}}};
      end else if (special_zero_i) begin
        result_o = {sign_i, {(FP_W-1){1'b0}}};
      end
    end
  end

endmodule

//--- source/fmul_top.sv
// Pipelined single-precision multiplier
`timescale 1ns/100ps

module fmul_top import fmul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  input  op_t      in_op_i,
  input  fp_word_t in_a_i,
  input  fp_word_t in_b_i,
  input  fp_word_t in_c_i,
  input  rm_t      in_rm_i,
  input  logic     out_ready_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output fp_word_t out_result_o,
  output fflags_t  out_fflags_o,
  output fp_word_t add_another_o,
  output op_t      op_o
);

  logic             en_s1;
  logic             en_s2;

  // stage 2
  logic             s2_sign;
  exp_calc_t        s2_exp;
  logic             s2_special;
  logic             s2_nan;
  logic             s2_inf;
  logic             s2_inv;
  logic             s2_zero;
  rm_t              s2_rm;
  prod_t            s2_prod;

  // stage 3
  logic [SIG_W+1:0] s3_sig;
  logic             s3_sticky;
  exp_calc_t        s3_exp;
  logic             s3_sign;
  logic             s3_special;
  logic             s3_nan;
  logic             s3_inf;
  logic             s3_inv;
  logic             s3_zero;
  rm_t              s3_rm;

  fmul_pipe_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .out_ready_i(out_ready_i),
    .in_op_i    (in_op_i),
    .in_c_i     (in_c_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .en_s1_o    (en_s1),
    .en_s2_o    (en_s2),
    .op_o       (op_o),
    .c_o        (add_another_o)
  );

  fmul_exp_path u_exp (
    .clk           (clk),
    .rst_n         (rst_n),
    .en_i          (en_s1),
    .a_i           (in_a_i),
    .b_i           (in_b_i),
    .op_i          (in_op_i),
    .rm_i          (in_rm_i),
    .sign_o        (s2_sign),
    .exp_o         (s2_exp),
    .special_o     (s2_special),
    .special_nan_o (s2_nan),
    .special_inf_o (s2_inf),
    .special_inv_o (s2_inv),
    .special_zero_o(s2_zero),
    .rm_o          (s2_rm)
  );

  fmul_sig_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .en_i  (en_s1),
    .a_i   (in_a_i),
    .b_i   (in_b_i),
    .prod_o(s2_prod)
  );

  fmul_normalize u_norm (
    .clk           (clk),
    .rst_n         (rst_n),
    .en_i          (en_s2),
    .prod_i        (s2_prod),
    .exp_i         (s2_exp),
    .sign_i        (s2_sign),
    .special_i     (s2_special),
    .special_nan_i (s2_nan),
    .special_inf_i (s2_inf),
    .special_inv_i (s2_inv),
    .special_zero_i(s2_zero),
    .rm_i          (s2_rm),
    .sig_o         (s3_sig),
    .sticky_o      (s3_sticky),
    .exp_o         (s3_exp),
    .sign_o        (s3_sign),
    .special_o     (s3_special),
    .special_nan_o (s3_nan),
    .special_inf_o (s3_inf),
    .special_inv_o (s3_inv),
    .special_zero_o(s3_zero),
    .rm_o          (s3_rm)
  );

  fmul_round u_round (
    .sig_i         (s3_sig),
    .sticky_i      (s3_sticky),
    .exp_i         (s3_exp),
    .sign_i        (s3_sign),
    .special_i     (s3_special),
    .special_nan_i (s3_nan),
    .special_inf_i (s3_inf),
    .special_inv_i (s3_inv),
    .special_zero_i(s3_zero),
    .rm_i          (s3_rm),
    .result_o      (out_result_o),
    .fflags_o      (out_fflags_o)
  );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYC = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYC) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- verif/tb_fmul.sv
// Floating-point multiplier testbench
`timescale 1ns/100ps

module tb_fmul import fmul_pkg::*; ();

  localparam int CLK_NS     = 10;
  localparam int RESET_CYC  = 10;
  localparam int N_PER_MODE = 30;
  localparam int N_SPECIAL  = 14;
  localparam int N_BP       = 120;
  // four random sets, three special passes, random ops, back-pressure
  localparam int TOTAL_ITEMS = 20 * N_PER_MODE + 3 * N_SPECIAL + 40 + N_BP;

  logic     clk;
  logic     rst_n;
  logic     in_valid_i;
  logic     out_ready_i = 1'b1;
  logic     in_ready_o;
  logic     out_valid_o;
  op_t      in_op_i;
  op_t      op_o;
  rm_t      in_rm_i;
  fp_word_t in_a_i;
  fp_word_t in_b_i;
  fp_word_t in_c_i;
  fp_word_t out_result_o;
  fp_word_t add_another_o;
  fflags_t  out_fflags_o;

  fp_word_t exp_res_q[$];
  fflags_t  exp_flags_q[$];
  fp_word_t exp_c_q[$];
  op_t      exp_op_q[$];
  longint   acc_cycle_q[$];

  integer   seed = 32'h9cfe9b76;
  int       errors = 0;
  int       checks = 0;
  int       sent = 0;
  longint   cycle = 0;
  logic     check_latency = 1'b0;
  logic     bp_mode = 1'b0;

  fp_word_t bp_a [N_BP];
  fp_word_t bp_b [N_BP];
  fp_word_t bp_c [N_BP];
  logic [31:0] bp_sel [N_BP];

  // NaN, infinity, zero, overflow and subnormal corner pairs
  fp_word_t special_a [N_SPECIAL] = '{
    32'h7fc00000, 32'h40000000, 32'h7f800000, 32'h80000000, 32'h7f800000,
    32'hff800000, 32'h00000000, 32'h80000000, 32'h00400000, 32'h7fc00000,
    32'h7f800001, 32'h7f7fffff, 32'h00000001, 32'h3f800000};
  fp_word_t special_b [N_SPECIAL] = '{
    32'h3f800000, 32'h7fa00000, 32'h00000000, 32'hff800000, 32'hc0400000,
    32'hff800000, 32'h40a00000, 32'h40e00000, 32'h00000000, 32'h7f800000,
    32'h00000000, 32'h7f7fffff, 32'h00000001, 32'h00000001};

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYC(RESET_CYC)) u_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  fmul_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .in_op_i      (in_op_i),
    .in_a_i       (in_a_i),
    .in_b_i       (in_b_i),
    .in_c_i       (in_c_i),
    .in_rm_i      (in_rm_i),
    .out_ready_i  (out_ready_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_fflags_o (out_fflags_o),
    .add_another_o(add_another_o),
    .op_o         (op_o)
  );

  // expected {result, flags} from the exact integer product
  function automatic logic [FP_W+FFLAGS_W-1:0] ref_fmul(input fp_word_t a, input fp_word_t b,
                                                        input op_t op, input rm_t rm);
    logic     sign;
    logic     a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
    logic     inexact, inc, ovf_inf;
    longint   ma, mb, p, kept, rem, half;
    int       ea, eb, e0, msb, be, sh;
    fp_word_t res;
    fflags_t  fl;
    sign   = a[31] ^ b[31] ^ ((op == OP_FNMADD) || (op == OP_FNMSUB));
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 0);
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 0);
    a_zero = (a[30:0] == 0);
    b_zero = (b[30:0] == 0);
    fl     = '0;
    if ((a_nan && !a[22]) || (b_nan && !b[22]) || (a_inf && b_zero) || (b_inf && a_zero)) begin
      fl[FLAG_NV] = 1'b1;
      return {CANON_NAN, fl};
    end
    if (a_nan || b_nan) begin
      return {CANON_NAN, fl};
    end
    if (a_inf || b_inf) begin
      return {sign, 8'hff, 23'd0, fl};
    end
    if (a_zero || b_zero) begin
      return {sign, 31'd0, fl};
    end
    // value is the integer p times 2^e0
    ea  = (a[30:23] == 0) ? 1 : int'(a[30:23]);
    eb  = (b[30:23] == 0) ? 1 : int'(b[30:23]);
    ma  = {a[30:23] != 8'd0, a[22:0]};
    mb  = {b[30:23] != 8'd0, b[22:0]};
    p   = ma * mb;
    e0  = ea + eb - 300;
    msb = 0;
    for (int i = 0; i < 48; i++) begin
      if (p[i]) begin
        msb = i;
      end
    end
    be = msb + e0 + 127;
    if (be < 1) begin
      be = 1;
    end
    // bits below the result lsb
    sh = be - 150 - e0;
    if (sh <= 0) begin
      kept = p << (-sh);
      rem  = 0;
      half = 1;
    end else if (sh > 50) begin
      kept = 0;
      rem  = 1;
      half = 2;
    end else begin
      kept = p >> sh;
      rem  = p & ((64'sd1 << sh) - 1);
      half = 64'sd1 << (sh - 1);
    end
    inexact = (rem != 0);
    case (rm)
      RM_RTZ:  inc = 1'b0;
      RM_RDN:  inc = inexact && sign;
      RM_RUP:  inc = inexact && !sign;
      RM_RMM:  inc = inexact && (rem >= half);
      default: inc = (rem > half) || ((rem == half) && kept[0]);
    endcase
    kept = kept + inc;
    if (kept >= (64'sd1 << 24)) begin
      kept = kept >> 1;
      be   = be + 1;
    end
    ovf_inf = (rm == RM_RNE) || (rm == RM_RMM) || ((rm == RM_RUP) && !sign) ||
              ((rm == RM_RDN) && sign);
    if (be >= 255) begin
      res         = ovf_inf ? {sign, 8'hff, 23'd0} : {sign, 8'hfe, 23'h7fffff};
      fl[FLAG_OF] = 1'b1;
      fl[FLAG_NX] = 1'b1;
    end else begin
      res         = {sign, kept[23] ? 8'(be) : 8'd0, kept[22:0]};
      fl[FLAG_NX] = inexact;
      fl[FLAG_UF] = inexact && !kept[23];
    end
    return {res, fl};
  endfunction

  function automatic fp_word_t rand_fp(input int e_lo, input int e_hi);
    logic [31:0] r;
    logic [31:0] f;
    r = $random(seed);
    f = $random(seed);
    return {r[31], 8'(e_lo + int'(r[15:0]) % (e_hi - e_lo + 1)), f[22:0]};
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // random output stall while back-pressure runs
  always @(posedge clk) begin
    if (bp_mode) begin
      out_ready_i <= ($random(seed) & 1) != 0;
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin : monitor
    fp_word_t er;
    fflags_t  ef;
    fp_word_t ec;
    op_t      eo;
    longint   acc;
    logic     exp_ready;
    logic     exp_valid;
    if (rst_n) begin
      // queue depth equals the items held in stages 2 and 3
      exp_ready = !((exp_res_q.size() == 2) && !out_ready_i);
      if (in_ready_o !== exp_ready) begin
        errors++;
        $display("ERR %0t in_ready_o exp=%b got=%b", $time, exp_ready, in_ready_o);
      end
      // oldest pending item sits in stage 3 from two cycles after it was taken
      exp_valid = (acc_cycle_q.size() != 0) && (cycle - acc_cycle_q[0] >= 2);
      if (out_valid_o !== exp_valid) begin
        errors++;
        $display("ERR %0t out_valid_o exp=%b got=%b", $time, exp_valid, out_valid_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_res_q.size() == 0) begin
          errors++;
          $display("result at %0t came with no input pending", $time);
        end else begin
          er  = exp_res_q.pop_front();
          ef  = exp_flags_q.pop_front();
          ec  = exp_c_q.pop_front();
          eo  = exp_op_q.pop_front();
          acc = acc_cycle_q.pop_front();
          checks++;
          if (out_result_o !== er) begin
            errors++;
            $display("ERR %0t out_result_o exp=%h got=%h", $time, er, out_result_o);
          end
          if (out_fflags_o !== ef) begin
            errors++;
            $display("ERR %0t out_fflags_o exp=%b got=%b", $time, ef, out_fflags_o);
          end
          if (add_another_o !== ec) begin
            errors++;
            $display("ERR %0t add_another_o exp=%h got=%h", $time, ec, add_another_o);
          end
          if (op_o !== eo) begin
            errors++;
            $display("ERR %0t op_o exp=%0d got=%0d", $time, eo, op_o);
          end
          if (check_latency && (cycle - acc != 2)) begin
            errors++;
            $display("result at %0t came %0d cycles after its input, not 2", $time, cycle - acc);
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        {er, ef} = ref_fmul(in_a_i, in_b_i, in_op_i, in_rm_i);
        exp_res_q.push_back(er);
        exp_flags_q.push_back(ef);
        exp_c_q.push_back(in_c_i);
        exp_op_q.push_back(in_op_i);
        acc_cycle_q.push_back(cycle);
      end
    end
  end

  task automatic send_item(input fp_word_t a, input fp_word_t b, input fp_word_t c,
                           input op_t op, input rm_t rm);
    in_valid_i <= 1'b1;
    in_a_i     <= a;
    in_b_i     <= b;
    in_c_i     <= c;
    in_op_i    <= op;
    in_rm_i    <= rm;
    sent++;
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
  endtask

  task automatic drain();
    in_valid_i <= 1'b0;
    do begin
      @(negedge clk);
    end while (exp_res_q.size() != 0);
    @(posedge clk);
  endtask

  task automatic run_random(input int ea_lo, input int ea_hi, input int eb_lo,
                            input int eb_hi, input int n, input logic any_op);
    for (int m = 0; m < 5; m++) begin
      for (int i = 0; i < n; i++) begin
        send_item(rand_fp(ea_lo, ea_hi), rand_fp(eb_lo, eb_hi), $random(seed),
                  any_op ? op_t'($random(seed)) : op_t'(0), rm_t'(m));
      end
    end
    drain();
  endtask

  task automatic run_specials(input op_t op);
    for (int i = 0; i < N_SPECIAL; i++) begin
      send_item(special_a[i], special_b[i], 32'(i), op, rm_t'(i % 5));
    end
    drain();
  endtask

  task automatic report_test(input string name, input int err_start, input int sent_start);
    $display("%s: %0d items, %0d errors", name, sent - sent_start, errors - err_start);
  endtask

  initial begin
    int err0;
    int sent0;
    in_valid_i = 1'b0;
    in_op_i    = '0;
    in_rm_i    = RM_RNE;
    in_a_i     = '0;
    in_b_i     = '0;
    in_c_i     = '0;

    err0 = errors;
    repeat (RESET_CYC + 1) begin
      @(negedge clk);
      if (out_valid_o !== 1'b0) begin
        errors++;
        $display("ERR %0t out_valid_o exp=0 got=%b", $time, out_valid_o);
      end
      if (in_ready_o !== 1'b1) begin
        errors++;
        $display("ERR %0t in_ready_o exp=1 got=%b", $time, in_ready_o);
      end
    end
    @(posedge clk);
    report_test("reset", err0, sent);

    err0  = errors;
    sent0 = sent;
    check_latency <= 1'b1;
    run_random(100, 150, 100, 150, N_PER_MODE, 1'b0);
    check_latency <= 1'b0;
    report_test("normal products", err0, sent0);

    err0  = errors;
    sent0 = sent;
    run_specials(op_t'(0));
    report_test("special values", err0, sent0);

    err0  = errors;
    sent0 = sent;
    run_random(200, 254, 200, 254, N_PER_MODE, 1'b0);
    run_random(1, 60, 1, 60, N_PER_MODE, 1'b0);
    run_random(0, 0, 100, 170, N_PER_MODE, 1'b0);
    report_test("range limits", err0, sent0);

    err0  = errors;
    sent0 = sent;
    run_random(110, 140, 110, 140, 8, 1'b1);
    run_specials(OP_FNMADD);
    run_specials(OP_FNMSUB);
    report_test("negation and sideband", err0, sent0);

    err0  = errors;
    sent0 = sent;
    for (int i = 0; i < N_BP; i++) begin
      bp_a[i]   = $random(seed);
      bp_b[i]   = $random(seed);
      bp_c[i]   = $random(seed);
      bp_sel[i] = $random(seed);
    end
    bp_mode <= 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      send_item(bp_a[i], bp_b[i], bp_c[i], op_t'(bp_sel[i][2:0]), rm_t'(bp_sel[i][5:3] % 5));
    end
    bp_mode <= 1'b0;
    drain();
    report_test("back-pressure", err0, sent0);

    $display("items %0d, results checked %0d, errors %0d", sent, checks, errors);
    if (errors == 0 && checks == sent) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #((TOTAL_ITEMS * 20 + RESET_CYC) * CLK_NS);
    $display("timeout: run did not finish within %0d cycles", TOTAL_ITEMS * 20 + RESET_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- flist.f
source/fmul_pkg.sv
source/fmul_pipe_ctrl.sv
source/fmul_exp_path.sv
source/fmul_sig_mult.sv
source/fmul_normalize.sv
source/fmul_round.sv
source/fmul_top.sv
verif/tb_clk_gen.sv
verif/tb_fmul.sv

//--- Bender.yml
package:
  name: fmul

sources:
  - source/fmul_pkg.sv
  - source/fmul_pipe_ctrl.sv
  - source/fmul_exp_path.sv
  - source/fmul_sig_mult.sv
  - source/fmul_normalize.sv
  - source/fmul_round.sv
  - source/fmul_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_fmul.sv
